// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define XLEN 32
`define REG_NUM 32
`define REG_AW 5
`define STAGE_NUM 5
`define RESET_PC 32'h0000_0000

// Base opcodes of the supported subset
`define OP_RTYPE 7'b0110011
`define OP_ITYPE 7'b0010011
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011
`define OP_BRANCH 7'b1100011

`endif

// ==== cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0]        imm;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0]         imm_hi;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [4:0]         imm_lo;
    logic [6:0]         opcode;
  } inst_s_t;

  // Branch offset bits are scattered over the word
  typedef struct packed {
    logic               imm_12;
    logic [5:0]         imm_10_5;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [3:0]         imm_4_1;
    logic               imm_11;
    logic [6:0]         opcode;
  } inst_b_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_b_t b;
  } inst_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR
  } alu_op_e;

  typedef struct packed {
    alu_op_e            alu_op;
    logic               b_imm;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   rs1_val;
    logic [`XLEN-1:0]   rs2_val;
    logic [`REG_AW-1:0] rd;
    logic               we;
    logic               load;
    logic               store;
  } id_ex_t;

  typedef struct packed {
    logic [`XLEN-1:0]   result;
    logic [`XLEN-1:0]   store_data;
    logic [`REG_AW-1:0] rd;
    logic               we;
    logic               load;
    logic               store;
  } ex_mem_t;

  typedef struct packed {
    logic [`XLEN-1:0]   result;
    logic [`REG_AW-1:0] rd;
    logic               we;
    logic               load;
  } mem_wb_t;

  typedef struct packed {
    logic [`REG_AW-1:0] rd;
    logic               we;
    logic [`XLEN-1:0]   value;
    logic               load;
  } fwd_t;

endpackage

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module regfile (
  input  logic              clk,
  input  logic              rstn,
  input  logic              we_i,
  input  logic [`REG_AW-1:0] waddr_i,
  input  logic [`XLEN-1:0]  wdata_i,
  input  logic [`REG_AW-1:0] raddr1_i,
  input  logic [`REG_AW-1:0] raddr2_i,
  output logic [`XLEN-1:0]  rdata1_o,
  output logic [`XLEN-1:0]  rdata2_o
);

  logic [`XLEN-1:0] regs [`REG_NUM];

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      for (int k = 0; k < `REG_NUM; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Writeback value bypasses the array in the same cycle
  assign rdata1_o = (raddr1_i == '0) ? '0 :
                    (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 :
                    (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// ==== ctrl.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module ctrl (
  input  logic                  stallreq_imem_i,
  input  logic                  stallreq_id_i,
  input  logic                  stallreq_dmem_i,
  output logic [`STAGE_NUM-1:0] stall_o
);

  // Highest stage wins, lower requests are covered by it
  always_comb begin
    if (stallreq_dmem_i) begin
      stall_o = 5'b01111;
    end else if (stallreq_id_i) begin
      stall_o = 5'b00011;
    end else if (stallreq_imem_i) begin
      stall_o = 5'b00001;
    end else begin
      stall_o = 5'b00000;
    end
  end

endmodule

// ==== ifetch.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module ifetch (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [`STAGE_NUM-1:0] stall_i,
  input  logic                  flush_i,
  input  logic [`XLEN-1:0]      branch_target_i,
  input  cpu_pkg::inst_u        inst_i,
  output logic [`XLEN-1:0]      inst_addr_o,
  output logic                  inst_read_o,
  output logic [`XLEN-1:0]      id_pc_o,
  output cpu_pkg::inst_u        id_inst_o
);

  logic [`XLEN-1:0] pc_q;

  // A taken branch redirects even while the fetch is waiting
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      pc_q <= `RESET_PC;
    end else if (flush_i) begin
      pc_q <= branch_target_i;
    end else if (!stall_i[0]) begin
      pc_q <= pc_q + `XLEN'(4);
    end
  end

  assign inst_addr_o = pc_q;
  assign inst_read_o = 1'b1;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      id_pc_o   <= '0;
      id_inst_o <= '0;
    end else if (!stall_i[1]) begin
      id_pc_o <= pc_q;
      // Wrong path or missing fetch becomes a bubble
      if (flush_i || stall_i[0]) begin
        id_inst_o <= '0;
      end else begin
        id_inst_o <= inst_i;
      end
    end
  end

endmodule

// ==== id.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module id (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [`STAGE_NUM-1:0] stall_i,
  input  logic [`XLEN-1:0]      pc_i,
  input  cpu_pkg::inst_u        inst_i,
  input  logic [`XLEN-1:0]      rs1_data_i,
  input  logic [`XLEN-1:0]      rs2_data_i,
  input  cpu_pkg::fwd_t         ex_fwd_i,
  input  cpu_pkg::fwd_t         mem_fwd_i,
  output logic [`REG_AW-1:0]    raddr1_o,
  output logic [`REG_AW-1:0]    raddr2_o,
  output logic                  stallreq_o,
  output logic                  flush_o,
  output logic [`XLEN-1:0]      branch_target_o,
  output cpu_pkg::id_ex_t       ex_o
);

  cpu_pkg::id_ex_t  dec;
  logic             use_rs1;
  logic             use_rs2;
  logic             is_beq;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;

  // Youngest producer first
  function automatic logic [`XLEN-1:0] fwd_value(input logic [`REG_AW-1:0] ra,
                                                  input logic [`XLEN-1:0] rf,
                                                  input cpu_pkg::fwd_t e,
                                                  input cpu_pkg::fwd_t m);
    return (e.we && e.rd == ra) ? e.value : (m.we && m.rd == ra) ? m.value : rf;
  endfunction

  // Load data is not ready before writeback
  function automatic logic fwd_pending(input logic [`REG_AW-1:0] ra,
                                       input cpu_pkg::fwd_t e,
                                       input cpu_pkg::fwd_t m);
    return (e.we && e.rd == ra) ? e.load : (m.we && m.rd == ra && m.load);
  endfunction

  assign raddr1_o = inst_i.r.rs1;
  assign raddr2_o = inst_i.r.rs2;

  assign imm_i = {{(`XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
  assign imm_s = {{(`XLEN-12){inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
  assign imm_b = {{(`XLEN-12){inst_i.b.imm_12}}, inst_i.b.imm_11, inst_i.b.imm_10_5,
                  inst_i.b.imm_4_1, 1'b0};

  assign op1 = fwd_value(inst_i.r.rs1, rs1_data_i, ex_fwd_i, mem_fwd_i);
  assign op2 = fwd_value(inst_i.r.rs2, rs2_data_i, ex_fwd_i, mem_fwd_i);

  always_comb begin
    dec         = '0;
    dec.alu_op  = cpu_pkg::ALU_ADD;
    dec.imm     = imm_i;
    dec.rd      = inst_i.r.rd;
    dec.rs1_val = op1;
    dec.rs2_val = op2;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    is_beq      = 1'b0;
    case (inst_i.r.opcode)
      `OP_RTYPE: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        dec.we  = 1'b1;
        case ({inst_i.r.funct7, inst_i.r.funct3})
          {7'h00, 3'b000}: dec.alu_op = cpu_pkg::ALU_ADD;
          {7'h20, 3'b000}: dec.alu_op = cpu_pkg::ALU_SUB;
          {7'h00, 3'b111}: dec.alu_op = cpu_pkg::ALU_AND;
          {7'h00, 3'b110}: dec.alu_op = cpu_pkg::ALU_OR;
          default: dec.we = 1'b0;
        endcase
      end
      `OP_ITYPE: begin
        use_rs1   = 1'b1;
        dec.b_imm = 1'b1;
        dec.we    = (inst_i.i.funct3 == 3'b000);
      end
      `OP_LOAD: begin
        use_rs1   = 1'b1;
        dec.b_imm = 1'b1;
        dec.load  = (inst_i.i.funct3 == 3'b010);
        dec.we    = dec.load;
      end
      `OP_STORE: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        dec.b_imm = 1'b1;
        dec.imm   = imm_s;
        dec.store = (inst_i.s.funct3 == 3'b010);
      end
      `OP_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        is_beq  = (inst_i.b.funct3 == 3'b000);
      end
      default: begin
      end
    endcase
    // x0 never produces a result
    dec.we = dec.we && (inst_i.r.rd != '0);
  end

  assign stallreq_o = (use_rs1 && fwd_pending(inst_i.r.rs1, ex_fwd_i, mem_fwd_i)) ||
                      (use_rs2 && fwd_pending(inst_i.r.rs2, ex_fwd_i, mem_fwd_i));

  assign flush_o         = is_beq && (op1 == op2) && !stall_i[1];
  assign branch_target_o = pc_i + imm_b;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      ex_o <= '0;
    end else if (!stall_i[2]) begin
      ex_o <= stall_i[1] ? '0 : dec;
    end
  end

endmodule

// ==== ex.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module ex (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [`STAGE_NUM-1:0] stall_i,
  input  cpu_pkg::id_ex_t       id_i,
  output cpu_pkg::fwd_t         fwd_o,
  output cpu_pkg::ex_mem_t      mem_o
);

  logic [`XLEN-1:0] opb;
  logic [`XLEN-1:0] result;

  assign opb = id_i.b_imm ? id_i.imm : id_i.rs2_val;

  // Loads and stores use the adder for the address
  always_comb begin
    case (id_i.alu_op)
      cpu_pkg::ALU_SUB: result = id_i.rs1_val - opb;
      cpu_pkg::ALU_AND: result = id_i.rs1_val & opb;
      cpu_pkg::ALU_OR:  result = id_i.rs1_val | opb;
      default:          result = id_i.rs1_val + opb;
    endcase
  end

  assign fwd_o.rd    = id_i.rd;
  assign fwd_o.we    = id_i.we;
  assign fwd_o.value = result;
  assign fwd_o.load  = id_i.load;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      mem_o <= '0;
    end else if (!stall_i[3]) begin
      if (stall_i[2]) begin
        mem_o <= '0;
      end else begin
        mem_o.result     <= result;
        mem_o.store_data <= id_i.rs2_val;
        mem_o.rd         <= id_i.rd;
        mem_o.we         <= id_i.we;
        mem_o.load       <= id_i.load;
        mem_o.store      <= id_i.store;
      end
    end
  end

endmodule

// ==== mem_wb.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module mem_wb (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic [`STAGE_NUM-1:0] stall_i,
  input  cpu_pkg::ex_mem_t      ex_i,
  input  logic [`XLEN-1:0]      data_in_i,
  output logic                  data_read_o,
  output logic                  data_write_o,
  output logic [`XLEN-1:0]      data_addr_o,
  output logic [`XLEN-1:0]      data_out_o,
  output cpu_pkg::fwd_t         fwd_o,
  output logic                  we_o,
  output logic [`REG_AW-1:0]    waddr_o,
  output logic [`XLEN-1:0]      wdata_o
);

  cpu_pkg::mem_wb_t wb_q;

  // Request is held steady by the frozen execute/memory register
  assign data_read_o  = ex_i.load;
  assign data_write_o = ex_i.store;
  assign data_addr_o  = ex_i.result;
  assign data_out_o   = ex_i.store_data;

  assign fwd_o.rd    = ex_i.rd;
  assign fwd_o.we    = ex_i.we;
  assign fwd_o.value = ex_i.result;
  assign fwd_o.load  = ex_i.load;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      wb_q <= '0;
    end else if (!stall_i[4]) begin
      if (stall_i[3]) begin
        wb_q <= '0;
      end else begin
        wb_q.result <= ex_i.result;
        wb_q.rd     <= ex_i.rd;
        wb_q.we     <= ex_i.we;
        wb_q.load   <= ex_i.load;
      end
    end
  end

  // Read data arrives during the writeback cycle
  assign we_o    = wb_q.we;
  assign waddr_o = wb_q.rd;
  assign wdata_o = wb_q.load ? data_in_i : wb_q.result;

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu (
  input  logic             clk,
  input  logic             rstn,
  // Instruction port
  input  logic [`XLEN-1:0] inst_in_i,
  output logic             inst_read_o,
  output logic [`XLEN-1:0] inst_addr_o,
  // Data port
  input  logic [`XLEN-1:0] data_in_i,
  output logic             data_read_o,
  output logic             data_write_o,
  output logic [`XLEN-1:0] data_addr_o,
  output logic [`XLEN-1:0] data_out_o,
  // Memory wait requests
  input  logic             stallreq_imem_i,
  input  logic             stallreq_dmem_i
);

  logic [`STAGE_NUM-1:0] stall;
  logic                  stallreq_id;
  logic                  flush;
  logic [`XLEN-1:0]      branch_target;

  logic [`XLEN-1:0]      id_pc;
  cpu_pkg::inst_u        id_inst;
  cpu_pkg::id_ex_t       id_ex;
  cpu_pkg::ex_mem_t      ex_mem;
  cpu_pkg::fwd_t         ex_fwd;
  cpu_pkg::fwd_t         mem_fwd;

  logic [`REG_AW-1:0]    raddr1;
  logic [`REG_AW-1:0]    raddr2;
  logic [`XLEN-1:0]      rdata1;
  logic [`XLEN-1:0]      rdata2;
  logic                  wb_we;
  logic [`REG_AW-1:0]    wb_addr;
  logic [`XLEN-1:0]      wb_data;

  regfile regfile0 (
    .clk      (clk),
    .rstn     (rstn),
    .we_i     (wb_we),
    .waddr_i  (wb_addr),
    .wdata_i  (wb_data),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  ctrl ctrl0 (
    .stallreq_imem_i (stallreq_imem_i),
    .stallreq_id_i   (stallreq_id),
    .stallreq_dmem_i (stallreq_dmem_i),
    .stall_o         (stall)
  );

  ifetch ifetch0 (
    .clk             (clk),
    .rstn            (rstn),
    .stall_i         (stall),
    .flush_i         (flush),
    .branch_target_i (branch_target),
    .inst_i          (inst_in_i),
    .inst_addr_o     (inst_addr_o),
    .inst_read_o     (inst_read_o),
    .id_pc_o         (id_pc),
    .id_inst_o       (id_inst)
  );

  id id0 (
    .clk             (clk),
    .rstn            (rstn),
    .stall_i         (stall),
    .pc_i            (id_pc),
    .inst_i          (id_inst),
    .rs1_data_i      (rdata1),
    .rs2_data_i      (rdata2),
    .ex_fwd_i        (ex_fwd),
    .mem_fwd_i       (mem_fwd),
    .raddr1_o        (raddr1),
    .raddr2_o        (raddr2),
    .stallreq_o      (stallreq_id),
    .flush_o         (flush),
    .branch_target_o (branch_target),
    .ex_o            (id_ex)
  );

  ex ex0 (
    .clk     (clk),
    .rstn    (rstn),
    .stall_i (stall),
    .id_i    (id_ex),
    .fwd_o   (ex_fwd),
    .mem_o   (ex_mem)
  );

  mem_wb mem_wb0 (
    .clk          (clk),
    .rstn         (rstn),
    .stall_i      (stall),
    .ex_i         (ex_mem),
    .data_in_i    (data_in_i),
    .data_read_o  (data_read_o),
    .data_write_o (data_write_o),
    .data_addr_o  (data_addr_o),
    .data_out_o   (data_out_o),
    .fwd_o        (mem_fwd),
    .we_o         (wb_we),
    .waddr_o      (wb_addr),
    .wdata_o      (wb_data)
  );

endmodule

// ==== tb_clk.sv ====
`timescale 1ns/1ps

module tb_clk (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset low for five rising edges, released just after the edge
  initial begin
    rstn_o = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rstn_o = 1'b1;
  end

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu;

  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] data;
  } store_t;

  localparam int prog_len = 29;
  localparam int num_stores = 10;
  localparam int max_stores = 32;
  localparam int max_stall_cycles = 100;
  localparam int quiet_cycles = 16;
  localparam int cycle_limit = 4 * prog_len + max_stall_cycles;

  localparam logic [31:0] program_words [prog_len] = '{
    32'h07500093,  // addi x1, x0, 0x75
    32'hFF000113,  // addi x2, x0, -16
    32'h002081B3,  // add  x3, x1, x2
    32'h00302023,  // sw   x3, 0(x0)
    32'h40208233,  // sub  x4, x1, x2
    32'h0020F2B3,  // and  x5, x1, x2
    32'h0020E333,  // or   x6, x1, x2
    32'h00402223,  // sw   x4, 4(x0)
    32'h00502423,  // sw   x5, 8(x0)
    32'h00602623,  // sw   x6, 12(x0)
    32'hFFF18393,  // addi x7, x3, -1
    32'h01038413,  // addi x8, x7, 16
    32'h008384B3,  // add  x9, x7, x8
    32'h00902823,  // sw   x9, 16(x0)
    32'h00402503,  // lw   x10, 4(x0)
    32'h001505B3,  // add  x11, x10, x1
    32'h00B02A23,  // sw   x11, 20(x0)
    32'h00C02603,  // lw   x12, 12(x0)
    32'h00C02C23,  // sw   x12, 24(x0)
    32'h00308463,  // beq  x1, x3, +8 (not taken)
    32'h00102E23,  // sw   x1, 28(x0)
    32'h00450463,  // beq  x10, x4, +8 (taken)
    32'h02202023,  // sw   x2, 32(x0) skipped
    32'h02802223,  // sw   x8, 36(x0)
    32'h02402683,  // lw   x13, 36(x0)
    32'h00868463,  // beq  x13, x8, +8 (taken)
    32'h02102423,  // sw   x1, 40(x0) skipped
    32'h02D02423,  // sw   x13, 40(x0)
    32'h00000063   // beq  x0, x0, 0
  };

  // Expected stores in program order, address then data
  localparam store_t store_table [num_stores] = '{
    '{32'h0000_0000, 32'h0000_0065},
    '{32'h0000_0004, 32'h0000_0085},
    '{32'h0000_0008, 32'h0000_0070},
    '{32'h0000_000C, 32'hFFFF_FFF5},
    '{32'h0000_0010, 32'h0000_00D8},
    '{32'h0000_0014, 32'h0000_00FA},
    '{32'h0000_0018, 32'hFFFF_FFF5},
    '{32'h0000_001C, 32'h0000_0075},
    '{32'h0000_0024, 32'h0000_0074},
    '{32'h0000_0028, 32'h0000_0074}
  };

  logic             clk;
  logic             rstn;
  logic [`XLEN-1:0] inst_in;
  logic             inst_read;
  logic [`XLEN-1:0] inst_addr;
  logic [`XLEN-1:0] data_in = '0;
  logic             data_read;
  logic             data_write;
  logic [`XLEN-1:0] data_addr;
  logic [`XLEN-1:0] data_out;
  logic             stallreq_imem = 1'b0;
  logic             stallreq_dmem = 1'b0;

  logic [31:0]      rom [64];
  logic [31:0]      ram [64];
  logic [31:0]      lfsr = 32'h1040_979e;
  logic             rd_pending = 1'b0;
  logic [5:0]       rd_word = '0;
  store_t           seen [max_stores];
  int               store_cnt = 0;
  int               stall_cycles = 0;
  int               cycle_cnt = 0;

  tb_clk clk_gen (
    .clk_o  (clk),
    .rstn_o (rstn)
  );

  cpu dut_i (
    .clk             (clk),
    .rstn            (rstn),
    .inst_in_i       (inst_in),
    .inst_read_o     (inst_read),
    .inst_addr_o     (inst_addr),
    .data_in_i       (data_in),
    .data_read_o     (data_read),
    .data_write_o    (data_write),
    .data_addr_o     (data_addr),
    .data_out_o      (data_out),
    .stallreq_imem_i (stallreq_imem),
    .stallreq_dmem_i (stallreq_dmem)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // Taps 32, 22, 2, 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b = lfsr[0];
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name,
                            input logic [31:0] got,
                            input logic [31:0] expected);
    assert (got == expected)
      else report_failure($sformatf("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                                    $time, name, got, expected));
  endtask

  initial begin
    for (int k = 0; k < 64; k++) begin
      rom[k] = '0;
      ram[k] = 32'h5a00_0000 + 32'(k * 4);
    end
    for (int k = 0; k < prog_len; k++) begin
      rom[k] = program_words[k];
    end
  end

  assign inst_in = inst_read ? rom[inst_addr[7:2]] : '0;

  // Requests are taken at the next rising edge unless the RAM holds them off
  always @(negedge clk) begin
    rd_pending = 1'b0;
    if (rstn && (data_read || data_write) && !stallreq_dmem) begin
      assert (data_addr[31:8] == '0 && data_addr[1:0] == 2'b00)
        else report_failure("Data access outside the 64-word RAM or not word aligned");
      if (data_read) begin
        rd_pending = 1'b1;
        rd_word = data_addr[7:2];
      end
      if (data_write) begin
        assert (store_cnt < max_stores)
          else report_failure("Too many stores on the data port");
        ram[data_addr[7:2]] = data_out;
        seen[store_cnt] = '{data_addr, data_out};
        store_cnt++;
      end
    end
  end

  // Stall requests and read data change just after each rising edge
  always @(posedge clk) begin
    logic active;
    logic b0;
    logic b1;
    logic b2;
    logic b3;
    active = rstn;
    #1;
    if (active && stall_cycles < max_stall_cycles) begin
      draw_bit(b0);
      draw_bit(b1);
      draw_bit(b2);
      draw_bit(b3);
      stallreq_imem = b0 & b1;
      stallreq_dmem = b2 & b3;
    end else begin
      stallreq_imem = 1'b0;
      stallreq_dmem = 1'b0;
    end
    if (stallreq_imem || stallreq_dmem) begin
      stall_cycles++;
    end
    data_in = rd_pending ? ram[rd_word] : 32'hdead_beef;
  end

  always @(posedge clk) begin
    if (rstn) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        report_failure($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                                 cycle_limit, store_cnt, num_stores));
      end
    end
  end

  initial begin
    store_t got;
    @(posedge rstn);
    // Port state straight out of reset
    check_word("inst_addr_o", inst_addr, `RESET_PC);
    check_word("inst_read_o", 32'(inst_read), 32'h1);
    check_word("data_read_o", 32'(data_read), 32'h0);
    check_word("data_write_o", 32'(data_write), 32'h0);
    for (int idx = 0; idx < num_stores; idx++) begin
      while (store_cnt <= idx) begin
        @(posedge clk);
      end
      got = seen[idx];
      check_word("data_addr_o", got.addr, store_table[idx].addr);
      check_word("data_out_o", got.data, store_table[idx].data);
    end
    // Self loop at the end must stay silent on the data port
    repeat (quiet_cycles) @(posedge clk);
    if (store_cnt != num_stores) begin
      report_failure($sformatf("Unexpected extra store after the last expected one, %0d in total",
                               store_cnt));
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

// ==== project.f ====
+incdir+.
cpu_pkg.sv
regfile.sv
ctrl.sv
ifetch.sv
id.sv
ex.sv
mem_wb.sv
cpu.sv
tb_clk.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cpu -f project.f -o tb_cpu &&
./obj_dir/tb_cpu 2>&1 | tee /dev/stderr | grep -q "Simulation completed successfully" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
